/* hw/fp27_macros.svh */
`ifndef FP27_MACROS_SVH
`define FP27_MACROS_SVH

// ======================================================================
// 27-bit float format
// ======================================================================

// Whole float word, sign + exponent + fraction
`define FP_W 27

// Biased exponent field
`define FP_EXP_W 8

// Stored fraction, leading one implied
`define FP_FRAC_W 18

// Exponent code of 2^0
`define FP_BIAS 127

// ======================================================================
// Integer side
// ======================================================================

// Signed operand and result width
`define INT_W 16

// Signed exponent shift amount
`define SHIFT_W 8

// Magnitude limit on float to int conversion
`define INT_MAX 32767

`endif

/* hw/fp27_pkg.sv */
`default_nettype none

`include "fp27_macros.svh"

package fp27_pkg;

	// Float word, sign on top, fraction at the bottom
	typedef struct packed {
		logic                  sign;
		logic [`FP_EXP_W-1:0]  exp;
		logic [`FP_FRAC_W-1:0] frac;
	} fp27_t;

	// Operation select
	typedef enum logic [2:0] {
		OP_MUL,
		OP_NEG,
		OP_ABS,
		OP_SHIFT,
		OP_CMP
	} fp_op_e;

	// Request into the unit
	typedef struct packed {
		logic                       valid;
		fp_op_e                     op;
		logic signed [`INT_W-1:0]   int_a;
		logic signed [`INT_W-1:0]   int_b;
		logic signed [`SHIFT_W-1:0] shift;
	} fp_request_t;

	// Converted operands, first stage out
	typedef struct packed {
		logic                       valid;
		fp_op_e                     op;
		fp27_t                      a;
		fp27_t                      b;
		logic signed [`SHIFT_W-1:0] shift;
	} fp_operands_t;

	// Float result, second stage out
	typedef struct packed {
		logic  valid;
		fp27_t value;
		logic  ge;
	} fp_result_t;

	// Response out of the unit
	typedef struct packed {
		logic                     valid;
		fp27_t                    value;
		logic                     ge;
		logic signed [`INT_W-1:0] int_val;
	} fp_response_t;

endpackage

`default_nettype wire

/* hw/fp_operand_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fp27_macros.svh"

module fp_operand_stage (
	input  logic                   iCLK,
	input  logic                   reset_key,
	input  fp27_pkg::fp_request_t  req,
	output fp27_pkg::fp_operands_t operands
);

	// ======================================================================
	// Signed integer to float
	// ======================================================================

	function automatic fp27_pkg::fp27_t int_to_fp(input logic signed [`INT_W-1:0] x);
		fp27_pkg::fp27_t                 f;
		logic                            sign;
		logic [`INT_W-1:0]               mag;
		logic [3:0]                      pos;
		logic [`INT_W+`FP_FRAC_W-1:0]    shift_buf;
		// Sign straight from the top bit
		sign = x[`INT_W-1];
		// Magnitude, -32768 lands on 16'h8000
		mag = sign ? -x : x;
		// Leading one search, highest set bit wins
		pos = 4'd0;
		for (int i = 0; i < `INT_W; i++) begin
			if (mag[i]) begin
				pos = 4'(i);
			end
		end
		// Leading one moved to bit 18, bits below it are the fraction
		shift_buf = {mag, {`FP_FRAC_W{1'b0}}} >> pos;
		f.sign = sign;
		f.exp  = `FP_EXP_W'(`FP_BIAS) + `FP_EXP_W'(pos);
		f.frac = shift_buf[`FP_FRAC_W-1:0];
		// Zero has no leading one
		if (x == '0) begin
			f = '0;
		end
		return f;
	endfunction

	// Both conversions in parallel
	fp27_pkg::fp27_t a_fp;
	fp27_pkg::fp27_t b_fp;

	assign a_fp = int_to_fp(req.int_a);
	assign b_fp = int_to_fp(req.int_b);

	// ======================================================================
	// Stage register
	// ======================================================================

	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			operands <= '0;
		end else begin
			// Strobe follows the request, one cycle later
			operands.valid <= req.valid;
			operands.op    <= req.op;
			operands.a     <= a_fp;
			operands.b     <= b_fp;
			// Shift only used by OP_SHIFT downstream
			operands.shift <= req.shift;
		end
	end

endmodule

`default_nettype wire

/* hw/fp_alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fp27_macros.svh"

module fp_alu (
	input  logic                   iCLK,
	input  logic                   reset_key,
	input  fp27_pkg::fp_operands_t operands,
	output fp27_pkg::fp_result_t   result
);

	// Operand aliases
	fp27_pkg::fp27_t a;
	fp27_pkg::fp27_t b;

	assign a = operands.a;
	assign b = operands.b;

	// ======================================================================
	// Multiply
	// ======================================================================

	// Mantissas, implied one plus top 17 fraction bits
	logic [`FP_FRAC_W-1:0]   man_a;
	logic [`FP_FRAC_W-1:0]   man_b;
	logic [2*`FP_FRAC_W-1:0] prod;
	// One extra bit for the exponent sum
	logic [`FP_EXP_W:0]      exp_sum;
	logic [`FP_EXP_W:0]      mul_exp;
	logic                    prod_top;
	logic                    mul_zero;
	fp27_pkg::fp27_t         mul_val;

	assign man_a = {1'b1, a.frac[`FP_FRAC_W-1:1]};
	assign man_b = {1'b1, b.frac[`FP_FRAC_W-1:1]};
	assign prod  = man_a * man_b;

	assign exp_sum  = {1'b0, a.exp} + {1'b0, b.exp};
	assign prod_top = prod[2*`FP_FRAC_W-1];

	// Product in [2,4) carries one more into the exponent
	assign mul_exp = prod_top ? exp_sum - 9'(`FP_BIAS - 1) : exp_sum - 9'(`FP_BIAS);

	// Underflow or a zero operand
	assign mul_zero = (exp_sum < 9'(`FP_BIAS + 1)) || (a.exp == '0) || (b.exp == '0);

	always_comb begin
		mul_val.sign = a.sign ^ b.sign;
		mul_val.exp  = mul_exp[`FP_EXP_W-1:0];
		// Normalize on the product's top bit
		if (prod_top) begin
			mul_val.frac = prod[2*`FP_FRAC_W-2:`FP_FRAC_W-1];
		end else begin
			mul_val.frac = prod[2*`FP_FRAC_W-3:`FP_FRAC_W-2];
		end
		if (mul_zero) begin
			mul_val = fp27_pkg::fp27_t'(`FP_W'(0));
		end
	end

	// ======================================================================
	// Compare, a >= b
	// ======================================================================

	logic mag_ge;
	logic mag_le;
	logic cmp_ge;

	// Magnitude order, exponent first then fraction
	assign mag_ge = (a.exp > b.exp) || ((a.exp == b.exp) && (a.frac >= b.frac));
	assign mag_le = (b.exp > a.exp) || ((a.exp == b.exp) && (b.frac >= a.frac));

	always_comb begin
		case ({a.sign, b.sign})
			// Positive vs negative
			2'b01: cmp_ge = 1'b1;
			2'b10: cmp_ge = 1'b0;
			// Both positive
			2'b00: cmp_ge = mag_ge;
			// Both negative, order flips
			default: cmp_ge = mag_le;
		endcase
	end

	// ======================================================================
	// Operation select
	// ======================================================================

	fp27_pkg::fp27_t next_value;
	logic            next_ge;

	always_comb begin
		// Pass a through, ge only for compare
		next_value = a;
		next_ge    = 1'b0;
		case (operands.op)
			fp27_pkg::OP_MUL:   next_value = mul_val;
			fp27_pkg::OP_NEG:   next_value.sign = ~a.sign;
			fp27_pkg::OP_ABS:   next_value.sign = 1'b0;
			// Wraps mod 256, no guard
			fp27_pkg::OP_SHIFT: next_value.exp = a.exp + operands.shift;
			fp27_pkg::OP_CMP:   next_ge = cmp_ge;
			default:            next_value = a;
		endcase
	end

	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			result <= '0;
		end else begin
			result.valid <= operands.valid;
			result.value <= next_value;
			result.ge    <= next_ge;
		end
	end

endmodule

`default_nettype wire

/* hw/fp_result_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fp27_macros.svh"

module fp_result_stage (
	input  logic                   iCLK,
	input  logic                   reset_key,
	input  fp27_pkg::fp_result_t   result,
	output fp27_pkg::fp_response_t rsp
);

	// ======================================================================
	// Float to signed integer
	// ======================================================================

	fp27_pkg::fp27_t              value;
	logic [`FP_EXP_W-1:0]         shift_amt;
	// Mantissa with room for the integer part above it
	logic [`INT_W+`FP_FRAC_W-1:0] shift_buf;
	logic [`INT_W-1:0]            int_mag;
	logic signed [`INT_W-1:0]     int_next;

	assign value = result.value;

	// Unbiased exponent, only meaningful inside the range below
	assign shift_amt = value.exp - `FP_EXP_W'(`FP_BIAS);
	assign shift_buf = {{(`INT_W-1){1'b0}}, 1'b1, value.frac} << shift_amt;

	// Integer part sits above the fraction bits
	assign int_mag = shift_buf[`INT_W+`FP_FRAC_W-1:`FP_FRAC_W];

	always_comb begin
		if (value.exp < `FP_EXP_W'(`FP_BIAS)) begin
			// Below one
			int_next = '0;
		end else if (value.exp > `FP_EXP_W'(`FP_BIAS + `INT_W - 2)) begin
			// Out of range, clip by sign
			int_next = value.sign ? -`INT_W'(`INT_MAX) : `INT_W'(`INT_MAX);
		end else begin
			int_next = value.sign ? -int_mag : int_mag;
		end
	end

	// Output register
	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			rsp <= '0;
		end else begin
			rsp.valid   <= result.valid;
			// Float and flag pass through
			rsp.value   <= result.value;
			rsp.ge      <= result.ge;
			rsp.int_val <= int_next;
		end
	end

endmodule

`default_nettype wire

/* hw/fp_calc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fp_calc_top (
	input  logic                   iCLK,
	input  logic                   reset_key,
	input  fp27_pkg::fp_request_t  req,
	output fp27_pkg::fp_response_t rsp
);

	// ======================================================================
	// Three-stage pipeline, one register per stage
	// ======================================================================

	// Stage 1 to stage 2
	fp27_pkg::fp_operands_t operands;
	// Stage 2 to stage 3
	fp27_pkg::fp_result_t   result;

	// Integer operands in, floats out
	fp_operand_stage u_operand_stage (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.req       (req),
		.operands  (operands)
	);

	// Selected float operation
	fp_alu u_alu (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.operands  (operands),
		.result    (result)
	);

	// Float back to a clipped integer
	fp_result_stage u_result_stage (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.result    (result),
		.rsp       (rsp)
	);

endmodule

`default_nettype wire

/* sim/fp_calc_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module fp_calc_properties (
	input logic                   iCLK,
	input logic                   reset_key,
	input fp27_pkg::fp_request_t  req,
	input fp27_pkg::fp_operands_t operands,
	input fp27_pkg::fp_result_t   result,
	input fp27_pkg::fp_response_t rsp
);

	// Edges since reset, saturates at pipeline depth
	logic [1:0] settled;

	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			settled <= 2'd0;
		end else if (settled != 2'd3) begin
			settled <= settled + 2'd1;
		end
	end

	// ======================================================================
	// Pipeline timing
	// ======================================================================

	// Strobe comes out three edges after it goes in
	assert property (@(posedge iCLK) (settled == 2'd3) |-> (rsp.valid == $past(req.valid, 3)))
		else $error("rsp valid does not follow req valid by three cycles");

	// Every stage strobe clear right after reset
	assert property (@(posedge iCLK) $fell(reset_key) |->
		!(operands.valid || result.valid || rsp.valid))
		else $error("valid bit set on the cycle after reset");

	// ======================================================================
	// Compare flag
	// ======================================================================

	// Flag at the output traces back to a compare three edges earlier
	assert property (@(posedge iCLK) rsp.ge |-> ($past(req.op, 3) == fp27_pkg::OP_CMP))
		else $error("ge raised for an operation other than compare");

endmodule

`default_nettype wire

/* sim/fp_calc_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fp27_macros.svh"

module fp_calc_tb;

	// ======================================================================
	// Run length and timing
	// ======================================================================

	localparam int N_ROUND    = 120;
	localparam int N_MUL      = 200;
	localparam int N_SHIFT    = 200;
	localparam int N_CMP      = 200;
	localparam int N_B2B      = 100;
	localparam int N_PRE_RST  = 8;
	localparam int N_POST_RST = 40;
	localparam int N_TOTAL    = N_ROUND + N_MUL + N_SHIFT + N_CMP + N_B2B + N_PRE_RST + N_POST_RST;
	localparam int CYCLE_LIMIT = N_TOTAL * 2 + 100;
	// Drive edge to the edge where the response is sampled
	localparam int RSP_DELAY = 4;

	logic                   iCLK;
	logic                   reset_key;
	fp27_pkg::fp_request_t  req;
	fp27_pkg::fp_response_t rsp;

	fp_calc_top UUT (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.req       (req),
		.rsp       (rsp)
	);

	bind fp_calc_top fp_calc_properties u_properties (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.req       (req),
		.operands  (operands),
		.result    (result),
		.rsp       (rsp)
	);

	initial iCLK = 1'b0;
	always #50 iCLK = ~iCLK;

	// Expected responses with their drive cycle
	fp27_pkg::fp_response_t exp_q[$];
	int                     issue_q[$];
	logic [31:0]            lcg_state;
	int tb_cycle    = 0;
	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;
	int err_mark    = 0;
	int chk_mark    = 0;
	int test_num    = 0;

	// Hard stop
	always @(posedge iCLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, %0d responses never arrived", cycle_count,
				exp_q.size());
			$display("Test failed");
			$finish;
		end
	end

	// ======================================================================
	// Random stimulus
	// ======================================================================

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Biased toward 0, +-1, -32768 and large magnitudes
	function automatic logic signed [`INT_W-1:0] rand_operand();
		logic [31:0] r;
		logic [31:0] v;
		r = next_rand();
		v = next_rand();
		case (r[31:29])
			3'd0: return '0;
			3'd1: return r[28] ? 16'sd1 : -16'sd1;
			3'd2: return 16'sh8000;
			// Magnitude at least 2^14
			3'd3: return {v[31], ~v[31], v[29:16]};
			default: return v[31:16];
		endcase
	endfunction

	// Half full range, half small shifts
	function automatic logic signed [`SHIFT_W-1:0] rand_shift();
		logic [31:0] r;
		r = next_rand();
		return r[31] ? r[23:16] : {{3{r[20]}}, r[20:16]};
	endfunction

	function automatic fp27_pkg::fp_op_e rand_op();
		logic [31:0] r;
		r = next_rand();
		return fp27_pkg::fp_op_e'(3'(r[31:16] % 16'd5));
	endfunction

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic fp27_pkg::fp27_t model_to_float(input int x);
		fp27_pkg::fp27_t f;
		int mag;
		int p;
		f = '0;
		if (x != 0) begin
			mag = (x < 0) ? -x : x;
			// Leading one position
			p = 0;
			while ((mag >> (p + 1)) != 0) begin
				p++;
			end
			f.sign = (x < 0);
			f.exp  = 8'(`FP_BIAS + p);
			f.frac = 18'((mag - (1 << p)) << (`FP_FRAC_W - p));
		end
		return f;
	endfunction

	function automatic int model_to_int(input fp27_pkg::fp27_t f);
		int     e;
		int     v;
		longint mant;
		e = int'(f.exp);
		if (e < `FP_BIAS) begin
			v = 0;
		end else if (e > `FP_BIAS + `INT_W - 2) begin
			v = `INT_MAX;
		end else begin
			mant = (longint'(1) << `FP_FRAC_W) | longint'(f.frac);
			v = int'((mant << (e - `FP_BIAS)) >> `FP_FRAC_W);
		end
		return f.sign ? -v : v;
	endfunction

	function automatic fp27_pkg::fp27_t model_mul(input fp27_pkg::fp27_t a,
		input fp27_pkg::fp27_t b);
		fp27_pkg::fp27_t r;
		int     sum;
		longint ma;
		longint mb;
		longint prod;
		r = '0;
		sum = int'(a.exp) + int'(b.exp);
		if (sum >= `FP_BIAS + 1 && a.exp != 0 && b.exp != 0) begin
			ma = (longint'(1) << 17) + longint'(a.frac >> 1);
			mb = (longint'(1) << 17) + longint'(b.frac >> 1);
			prod = ma * mb;
			r.sign = a.sign ^ b.sign;
			// Product of two values in [1,2) may reach [2,4)
			if (prod >= (longint'(1) << 35)) begin
				r.exp  = 8'(sum - (`FP_BIAS - 1));
				r.frac = 18'(prod >> 17);
			end else begin
				r.exp  = 8'(sum - `FP_BIAS);
				r.frac = 18'(prod >> 16);
			end
		end
		return r;
	endfunction

	function automatic logic model_ge(input fp27_pkg::fp27_t a, input fp27_pkg::fp27_t b);
		logic [25:0] ka;
		logic [25:0] kb;
		ka = {a.exp, a.frac};
		kb = {b.exp, b.frac};
		if (a.sign != b.sign) begin
			return !a.sign;
		end else if (!a.sign) begin
			return ka >= kb;
		end
		// Both negative, smaller magnitude is the larger value
		return ka <= kb;
	endfunction

	function automatic fp27_pkg::fp_response_t model_response(input fp27_pkg::fp_op_e op,
		input logic signed [`INT_W-1:0] ia, input logic signed [`INT_W-1:0] ib,
		input logic signed [`SHIFT_W-1:0] sh);
		fp27_pkg::fp_response_t r;
		fp27_pkg::fp27_t        fa;
		fp27_pkg::fp27_t        fb;
		fp27_pkg::fp27_t        v;
		r  = '0;
		fa = model_to_float(int'(ia));
		fb = model_to_float(int'(ib));
		v  = fa;
		case (op)
			fp27_pkg::OP_MUL:   v = model_mul(fa, fb);
			fp27_pkg::OP_NEG:   v.sign = !fa.sign;
			fp27_pkg::OP_ABS:   v.sign = 1'b0;
			// Exponent wraps mod 256
			fp27_pkg::OP_SHIFT: v.exp = 8'(int'(fa.exp) + int'(sh));
			fp27_pkg::OP_CMP:   r.ge = model_ge(fa, fb);
			default:            v = fa;
		endcase
		r.valid   = 1'b1;
		r.value   = v;
		r.int_val = 16'(model_to_int(v));
		return r;
	endfunction

	// ======================================================================
	// Driving and checking
	// ======================================================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("Mismatch %s: got %h, expected %h at cycle %0d", name, got, expected,
				tb_cycle);
		end
	endtask

	task automatic check_response();
		fp27_pkg::fp_response_t expected;
		int                     issued;
		if (rsp.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				error_count++;
				$display("Response at cycle %0d with no request pending", tb_cycle);
			end else begin
				expected = exp_q.pop_front();
				issued   = issue_q.pop_front();
				check_value("rsp.value", 32'(rsp.value), 32'(expected.value));
				check_value("rsp.ge", 32'(rsp.ge), 32'(expected.ge));
				check_value("rsp.int_val", 32'(rsp.int_val), 32'(expected.int_val));
				check_value("latency", 32'(tb_cycle - issued), 32'(RSP_DELAY));
			end
		end else if (issue_q.size() != 0 && tb_cycle - issue_q[0] >= RSP_DELAY) begin
			// Head request is overdue, drop it so later ones still line up
			error_count++;
			$display("No response for the request driven at cycle %0d", issue_q[0]);
			void'(exp_q.pop_front());
			void'(issue_q.pop_front());
		end
	endtask

	task automatic next_cycle();
		@(posedge iCLK);
		tb_cycle++;
		check_response();
	endtask

	task automatic issue(input fp27_pkg::fp_op_e op, input logic signed [`INT_W-1:0] a,
		input logic signed [`INT_W-1:0] b, input logic signed [`SHIFT_W-1:0] sh,
		input logic gaps);
		fp27_pkg::fp_request_t r;
		logic [31:0]           gap;
		// Valid on about 3 cycles in 4
		if (gaps) begin
			gap = next_rand();
			while (gap[31:30] == 2'b00) begin
				req.valid <= 1'b0;
				next_cycle();
				gap = next_rand();
			end
		end
		r.valid = 1'b1;
		r.op    = op;
		r.int_a = a;
		r.int_b = b;
		r.shift = sh;
		req <= r;
		exp_q.push_back(model_response(op, a, b, sh));
		issue_q.push_back(tb_cycle);
		next_cycle();
	endtask

	task automatic start_test();
		err_mark = error_count;
		chk_mark = check_count;
	endtask

	// Drain the pipeline, a couple of spare cycles catch stray valids
	task automatic finish_test(input string name);
		req <= '0;
		while (exp_q.size() != 0) begin
			next_cycle();
		end
		repeat (2) next_cycle();
		test_num++;
		$display("[%0d] %s: %0d checks, %0d errors", test_num, name,
			check_count - chk_mark, error_count - err_mark);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		logic signed [`INT_W-1:0]   a;
		logic signed [`INT_W-1:0]   b;
		logic signed [`SHIFT_W-1:0] sh;
		logic [31:0]                r;
		fp27_pkg::fp_op_e           op;
		lcg_state = 32'h7275_1b55;
		reset_key = 1'b1;
		req       = '0;
		repeat (5) @(posedge iCLK);
		reset_key <= 1'b0;

		// Round trip, -32768 first under both ops
		start_test();
		for (int i = 0; i < N_ROUND; i++) begin
			a = (i < 2) ? 16'sh8000 : rand_operand();
			r = next_rand();
			if (i < 2) begin
				op = (i == 0) ? fp27_pkg::OP_ABS : fp27_pkg::OP_NEG;
			end else begin
				op = r[31] ? fp27_pkg::OP_ABS : fp27_pkg::OP_NEG;
			end
			issue(op, a, 16'sd0, 8'sd0, 1'b1);
		end
		finish_test("abs/neg round trip");

		start_test();
		for (int i = 0; i < N_MUL; i++) begin
			a = rand_operand();
			b = rand_operand();
			issue(fp27_pkg::OP_MUL, a, b, 8'sd0, 1'b1);
		end
		finish_test("multiply");

		start_test();
		for (int i = 0; i < N_SHIFT; i++) begin
			a  = rand_operand();
			sh = rand_shift();
			issue(fp27_pkg::OP_SHIFT, a, 16'sd0, sh, 1'b1);
		end
		finish_test("exponent shift");

		// Some equal pairs, some opposite signs
		start_test();
		for (int i = 0; i < N_CMP; i++) begin
			a = rand_operand();
			b = rand_operand();
			r = next_rand();
			if (r[31:30] == 2'd0) begin
				b = a;
			end else if (r[31:30] == 2'd1) begin
				b = -a;
			end
			issue(fp27_pkg::OP_CMP, a, b, 8'sd0, 1'b1);
		end
		finish_test("compare");

		start_test();
		for (int i = 0; i < N_B2B; i++) begin
			op = rand_op();
			a  = rand_operand();
			b  = rand_operand();
			sh = rand_shift();
			issue(op, a, b, sh, 1'b0);
		end
		finish_test("back to back");

		// Reset with items in flight
		start_test();
		for (int i = 0; i < N_PRE_RST; i++) begin
			op = rand_op();
			a  = rand_operand();
			b  = rand_operand();
			issue(op, a, b, 8'sd1, 1'b0);
		end
		reset_key <= 1'b1;
		req       <= '0;
		next_cycle();
		exp_q.delete();
		issue_q.delete();
		repeat (2) next_cycle();
		reset_key <= 1'b0;
		// Idle, any valid here counts as extra
		repeat (8) next_cycle();
		for (int i = 0; i < N_POST_RST; i++) begin
			op = rand_op();
			a  = rand_operand();
			b  = rand_operand();
			sh = rand_shift();
			issue(op, a, b, sh, 1'b1);
		end
		finish_test("reset in mid-run");

		$display("Total: %0d tests, %0d checks, %0d errors", test_num, check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hw
hw/fp27_pkg.sv
hw/fp_operand_stage.sv
hw/fp_alu.sv
hw/fp_result_stage.sv
hw/fp_calc_top.sv
sim/fp_calc_properties.sv
sim/fp_calc_tb.sv

/* Makefile */
# Verilator build and run of the FP27 pipeline testbench

VERILATOR ?= verilator
TOP       ?= fp_calc_tb
FILELIST  ?= tb.f
SEED_LOG  ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/fp27_macros.svh

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(SEED_LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(SEED_LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST SEED_LOG BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(SEED_LOG) 2>&1; cat $(SEED_LOG)
	@if grep -q "Test failed" $(SEED_LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "Test passed" $(SEED_LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)
